// File: src.f
hw/link_pkg.sv
hw/flit_buffer.sv
hw/flow_serializer.sv
hw/flow_deserializer.sv
hw/link_endpoint.sv
bench/tb_clock.sv
bench/link_endpoint_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the link endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f src.f --top-module link_endpoint_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vlink_endpoint_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The verdict comes from the log
if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
exit 0

// File: bench/link_endpoint_tb.sv
`timescale 1ns/10ps
`default_nettype none

module link_endpoint_tb;

  logic                                clk;
  logic                                rst_n;
  logic                                wide_valid;
  logic                                wide_ready;
  logic [link_pkg::WIDE_WIDTH-1:0]     wide_data;
  logic                                wide_last;
  logic [link_pkg::SLICE_ID_WIDTH-1:0] wide_dont_care;
  logic [link_pkg::TAG_WIDTH-1:0]      wide_tag;
  logic                                tx_valid;
  logic                                tx_ready;
  logic [link_pkg::NARROW_WIDTH-1:0]   tx_data;
  logic                                tx_last;
  logic [link_pkg::TAG_WIDTH-1:0]      tx_tag;
  logic                                rx_valid;
  logic                                rx_ready;
  logic                                link_gate;
  logic                                out_valid;
  logic                                out_ready;
  logic [link_pkg::WIDE_WIDTH-1:0]     out_data;
  logic                                out_last;
  logic [link_pkg::SLICE_ID_WIDTH-1:0] out_dont_care;
  logic [link_pkg::TAG_WIDTH-1:0]      out_tag;

  // Expected slices on tx and expected flits on out, oldest first
  logic [link_pkg::NARROW_WIDTH-1:0]   slice_q[$];
  logic                                slice_last_q[$];
  logic [link_pkg::TAG_WIDTH-1:0]      slice_tag_q[$];
  logic [link_pkg::WIDE_WIDTH-1:0]     flit_q[$];
  logic                                flit_last_q[$];
  logic [link_pkg::SLICE_ID_WIDTH-1:0] flit_dc_q[$];
  logic [link_pkg::TAG_WIDTH-1:0]      flit_tag_q[$];

  string       test_name;
  int          error_count;
  int          errors_before;
  int          tests_run;
  bit          hung;
  bit          rand_ready;
  logic [31:0] lcg_state;

  // Snapshot of the tx outputs from the previous rising edge
  bit                                stalled;
  logic [link_pkg::NARROW_WIDTH-1:0] held_data;
  logic                              held_last;
  logic [link_pkg::TAG_WIDTH-1:0]    held_tag;

  tb_clock u_tb_clock (.clk(clk));

  // The link gate stalls both ends of the loopback together, so a slice
  // leaves tx exactly when it enters rx
  assign tx_ready = rx_ready && link_gate;
  assign rx_valid = tx_valid && link_gate;

  link_endpoint DUT (
    .clk(clk), .rst_n(rst_n),
    .wide_valid(wide_valid), .wide_ready(wide_ready), .wide_data(wide_data),
    .wide_last(wide_last), .wide_dont_care(wide_dont_care), .wide_tag(wide_tag),
    .tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data),
    .tx_last(tx_last), .tx_tag(tx_tag),
    .rx_valid(rx_valid), .rx_ready(rx_ready), .rx_data(tx_data),
    .rx_last(tx_last), .rx_tag(tx_tag),
    .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
    .out_last(out_last), .out_dont_care(out_dont_care), .out_tag(out_tag)
  );

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // Linear congruential generator whose upper bits are the most random ones
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic logic [31:0] random_word();
    logic [15:0] hi;
    hi = next_rand();
    return {hi, next_rand()};
  endfunction

  task automatic report_problem(input string msg);
    error_count++;
    $display("Problem in test %s: %s", test_name, msg);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      error_count++;
      $display("Error %s: %s expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // Move to the next falling edge and pick new readies there
  task automatic step_cycle();
    logic [15:0] r;
    @(negedge clk);
    r = next_rand();
    link_gate = rand_ready ? (r[15:14] != 2'b00) : 1'b1;
    out_ready = rand_ready ? r[13] : 1'b1;
  endtask

  // A flit is sent as its lowest slices, the tail of a last flit is dropped
  // and comes back as zeros with the same marker, count and tag
  task automatic record_flit(input logic [link_pkg::WIDE_WIDTH-1:0] data, input logic last,
                             input logic [link_pkg::SLICE_ID_WIDTH-1:0] dc,
                             input logic [link_pkg::TAG_WIDTH-1:0] tag);
    int n;
    int i;
    logic [link_pkg::WIDE_WIDTH-1:0] kept;
    n = last ? link_pkg::SLICE_RATIO - int'(dc) : link_pkg::SLICE_RATIO;
    kept = data;
    for (i = 0; i < link_pkg::SLICE_RATIO; i++) begin
      if (i < n) begin
        slice_q.push_back(data[i*link_pkg::NARROW_WIDTH +: link_pkg::NARROW_WIDTH]);
        slice_last_q.push_back(last && (i == n - 1));
        slice_tag_q.push_back(tag);
      end else begin
        kept[i*link_pkg::NARROW_WIDTH +: link_pkg::NARROW_WIDTH] = '0;
      end
    end
    flit_q.push_back(kept);
    flit_last_q.push_back(last);
    flit_dc_q.push_back(last ? dc : '0);
    flit_tag_q.push_back(tag);
  endtask

  // Offer one wide flit and return on the falling edge after it is taken
  task automatic send_flit(input logic [link_pkg::WIDE_WIDTH-1:0] data, input logic last,
                           input logic [link_pkg::SLICE_ID_WIDTH-1:0] dc,
                           input logic [link_pkg::TAG_WIDTH-1:0] tag);
    int waited;
    if (hung) return;
    waited = 0;
    wide_valid = 1'b1;
    wide_data = data;
    wide_last = last;
    wide_dont_care = dc;
    wide_tag = tag;
    // Ready depends only on the buffer count, so it holds until the edge
    while (!wide_ready && waited < 200) begin
      step_cycle();
      waited++;
    end
    if (wide_ready) begin
      record_flit(data, last, dc, tag);
      step_cycle();
    end else begin
      hung = 1'b1;
      $display("Timeout in test %s: wide_ready stayed low", test_name);
    end
    wide_valid = 1'b0;
  endtask

  // Let everything in flight come out at the far end
  task automatic wait_drain();
    int waited;
    if (hung) return;
    waited = 0;
    while ((flit_q.size() != 0 || tx_valid || out_valid) && waited < 2000) begin
      step_cycle();
      waited++;
    end
    if (flit_q.size() != 0 || tx_valid || out_valid) begin
      hung = 1'b1;
      $display("Timeout in test %s: %0d flits never came back", test_name, flit_q.size());
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_before = error_count;
  endtask

  task automatic finish_test();
    tests_run++;
    $display("Test %s finished with %0d errors", test_name, error_count - errors_before);
  endtask

  // --------------------------------------------------
  // Monitor that samples on the rising edge
  // --------------------------------------------------

  always @(posedge clk) begin
    if (rst_n) begin
      // A stalled slice must stay exactly as it was offered
      if (stalled) begin
        assert (tx_valid && tx_data === held_data && tx_last === held_last
                && tx_tag === held_tag)
        else report_problem("tx outputs changed while tx_ready was low");
      end
      // The receive side stalls only behind a full output register
      check_value("rx_ready", 32'(!(out_valid && !out_ready)), 32'(rx_ready));
      if (tx_valid && tx_ready) begin
        assert (slice_q.size() != 0) else report_problem("a slice left with none expected");
        if (slice_q.size() != 0) begin
          check_value("tx_data", 32'(slice_q.pop_front()), 32'(tx_data));
          check_value("tx_last", 32'(slice_last_q.pop_front()), 32'(tx_last));
          check_value("tx_tag", 32'(slice_tag_q.pop_front()), 32'(tx_tag));
        end
      end
      if (out_valid && out_ready) begin
        assert (flit_q.size() != 0) else report_problem("a wide flit came out unexpected");
        if (flit_q.size() != 0) begin
          check_value("out_data", flit_q.pop_front(), out_data);
          check_value("out_last", 32'(flit_last_q.pop_front()), 32'(out_last));
          check_value("out_dont_care", 32'(flit_dc_q.pop_front()), 32'(out_dont_care));
          check_value("out_tag", 32'(flit_tag_q.pop_front()), 32'(out_tag));
        end
      end
    end
    stalled = rst_n && tx_valid && !tx_ready;
    held_data = tx_data;
    held_last = tx_last;
    held_tag = tx_tag;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int p;
    int f;
    int nflits;
    int d;
    logic [15:0] r;
    rst_n = 1'b0;
    wide_valid = 1'b0;
    wide_data = '0;
    wide_last = 1'b0;
    wide_dont_care = '0;
    wide_tag = '0;
    link_gate = 1'b1;
    out_ready = 1'b1;
    lcg_state = 32'd63;
    error_count = 0;
    tests_run = 0;
    hung = 1'b0;
    rand_ready = 1'b0;
    stalled = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    start_test("reset_state");
    assert (!tx_valid) else report_problem("tx_valid is high after reset");
    assert (!out_valid) else report_problem("out_valid is high after reset");
    assert (wide_ready) else report_problem("wide_ready is low after reset");
    finish_test();

    // First slice must show in the cycle right after the flit is taken
    start_test("full_flit");
    send_flit(random_word(), 1'b0, '0, 3'd5);
    assert (hung || tx_valid) else report_problem("no slice in the cycle after the push");
    send_flit(random_word(), 1'b1, '0, 3'd2);
    wait_drain();
    finish_test();

    start_test("last_flit_tail");
    for (d = 0; d < link_pkg::SLICE_RATIO; d++) begin
      send_flit(random_word(), 1'b1, (link_pkg::SLICE_ID_WIDTH)'(d), (link_pkg::TAG_WIDTH)'(d));
    end
    wait_drain();
    finish_test();

    start_test("round_trip");
    for (p = 0; p < 4; p++) begin
      for (f = 0; f < 3; f++) begin
        r = next_rand();
        send_flit(random_word(), f == 2, (f == 2) ? r[1:0] : 2'd0, r[6:4]);
      end
    end
    wait_drain();
    finish_test();

    start_test("random_traffic");
    rand_ready = 1'b1;
    for (p = 0; p < 40; p++) begin
      r = next_rand();
      nflits = 1 + int'(r[9:8] % 2'd3);
      for (f = 0; f < nflits; f++) begin
        r = next_rand();
        send_flit(random_word(), f == nflits - 1, (f == nflits - 1) ? r[1:0] : 2'd0, r[6:4]);
        if (r[12] && !hung) step_cycle();
      end
    end
    wait_drain();
    rand_ready = 1'b0;
    finish_test();

    $display("Tests run %0d, errors %0d", tests_run, error_count);
    if (error_count == 0 && !hung) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

// Free-running clock for the link endpoint testbench
module tb_clock (
  output logic clk
);

  // Start low so the first rising edge falls at 50 ns
  initial begin
    clk = 1'b0;
  end

  // Half of the 100 ns period
  always begin
    #50 clk = ~clk;
  end

endmodule

`default_nettype wire

// File: hw/link_endpoint.sv
`timescale 1ns/10ps
`default_nettype none

// Endpoint of the narrow link
// Transmit path is buffer then serializer, receive path is the deserializer
module link_endpoint (
  input  wire logic                                clk,
  input  wire logic                                rst_n,

  // Wide flits coming in for transmission
  input  wire logic                                wide_valid,
  output logic                                     wide_ready,
  input  wire logic [link_pkg::WIDE_WIDTH-1:0]     wide_data,
  input  wire logic                                wide_last,
  input  wire logic [link_pkg::SLICE_ID_WIDTH-1:0] wide_dont_care,
  input  wire logic [link_pkg::TAG_WIDTH-1:0]      wide_tag,

  // Narrow slices leaving on the link
  output logic                                     tx_valid,
  input  wire logic                                tx_ready,
  output logic [link_pkg::NARROW_WIDTH-1:0]        tx_data,
  output logic                                     tx_last,
  output logic [link_pkg::TAG_WIDTH-1:0]           tx_tag,

  // Narrow slices arriving from the link
  input  wire logic                                rx_valid,
  output logic                                     rx_ready,
  input  wire logic [link_pkg::NARROW_WIDTH-1:0]   rx_data,
  input  wire logic                                rx_last,
  input  wire logic [link_pkg::TAG_WIDTH-1:0]      rx_tag,

  // Rebuilt wide flits
  output logic                                     out_valid,
  input  wire logic                                out_ready,
  output logic [link_pkg::WIDE_WIDTH-1:0]          out_data,
  output logic                                     out_last,
  output logic [link_pkg::SLICE_ID_WIDTH-1:0]      out_dont_care,
  output logic [link_pkg::TAG_WIDTH-1:0]           out_tag
);

  // --------------------------------------------------
  // Buffer to serializer
  // --------------------------------------------------

  logic                                buf_valid;
  logic                                buf_ready;
  logic [link_pkg::WIDE_WIDTH-1:0]     buf_data;
  logic                                buf_last;
  logic [link_pkg::SLICE_ID_WIDTH-1:0] buf_dont_care;
  logic [link_pkg::TAG_WIDTH-1:0]      buf_tag;

  // Holds each flit steady while it is being sliced
  flit_buffer u_flit_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (wide_valid),
    .in_ready     (wide_ready),
    .in_data      (wide_data),
    .in_last      (wide_last),
    .in_dont_care (wide_dont_care),
    .in_tag       (wide_tag),
    .out_valid    (buf_valid),
    .out_ready    (buf_ready),
    .out_data     (buf_data),
    .out_last     (buf_last),
    .out_dont_care(buf_dont_care),
    .out_tag      (buf_tag)
  );

  flow_serializer u_flow_serializer (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_valid    (buf_valid),
    .push_ready    (buf_ready),
    .push_data     (buf_data),
    .push_last     (buf_last),
    .push_dont_care(buf_dont_care),
    .push_tag      (buf_tag),
    .pop_valid     (tx_valid),
    .pop_ready     (tx_ready),
    .pop_data      (tx_data),
    .pop_last      (tx_last),
    .pop_tag       (tx_tag)
  );

  // --------------------------------------------------
  // Receive path
  // --------------------------------------------------

  flow_deserializer u_flow_deserializer (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_valid     (rx_valid),
    .in_ready     (rx_ready),
    .in_data      (rx_data),
    .in_last      (rx_last),
    .in_tag       (rx_tag),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_last     (out_last),
    .out_dont_care(out_dont_care),
    .out_tag      (out_tag)
  );

endmodule

`default_nettype wire

// File: hw/flow_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

// Gathers narrow slices back into a wide flit
// The finished flit sits in an output register until it is taken, and
// the tail dropped by the far side comes back as zeros
module flow_deserializer (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                in_valid,
  output logic                                     in_ready,
  input  wire logic [link_pkg::NARROW_WIDTH-1:0]   in_data,
  input  wire logic                                in_last,
  input  wire logic [link_pkg::TAG_WIDTH-1:0]      in_tag,
  output logic                                     out_valid,
  input  wire logic                                out_ready,
  output logic [link_pkg::WIDE_WIDTH-1:0]          out_data,
  output logic                                     out_last,
  output logic [link_pkg::SLICE_ID_WIDTH-1:0]      out_dont_care,
  output logic [link_pkg::TAG_WIDTH-1:0]           out_tag
);

  // --------------------------------------------------
  // Assembly state
  // --------------------------------------------------

  // Position the next incoming slice will be written to
  logic [link_pkg::SLICE_ID_WIDTH-1:0] slice_cnt;

  // Partial flit and the tag taken from its first slice
  logic [link_pkg::WIDE_WIDTH-1:0]     asm_data;
  logic [link_pkg::TAG_WIDTH-1:0]      asm_tag;

  // Partial flit with the current slice merged in
  logic [link_pkg::WIDE_WIDTH-1:0]     asm_data_next;
  logic [link_pkg::TAG_WIDTH-1:0]      asm_tag_next;

  // Number of tail slices that never arrived
  logic [link_pkg::SLICE_ID_WIDTH-1:0] final_dc;

  logic                                in_fire;
  logic                                first_slice;
  logic                                final_slice;

  // Only a full output register that is not being drained stalls the link
  assign in_ready = !out_valid || out_ready;

  assign in_fire     = in_valid && in_ready;
  assign first_slice = (slice_cnt == '0);

  // The top position ends a flit, and so does the end of a packet
  assign final_slice =
    (slice_cnt == (link_pkg::SLICE_ID_WIDTH)'(link_pkg::SLICE_RATIO - 1)) || in_last;

  // Whatever lies above the final index was dropped by the sender
  assign final_dc =
    (link_pkg::SLICE_ID_WIDTH)'(link_pkg::SLICE_RATIO - 1) - slice_cnt;

  always_comb begin
    // A new flit starts from zeros, so positions above its final slice
    // read back as zero even when the tail is never sent
    if (first_slice) begin
      asm_data_next = '0;
      asm_tag_next  = in_tag;
    end else begin
      asm_data_next = asm_data;
      asm_tag_next  = asm_tag;
    end
    asm_data_next[slice_cnt * link_pkg::NARROW_WIDTH +: link_pkg::NARROW_WIDTH] = in_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slice_cnt <= '0;
    end else if (in_fire) begin
      if (final_slice) begin
        slice_cnt <= '0;
      end else begin
        slice_cnt <= slice_cnt + 1'b1;
      end
    end
  end

  // The partial flit is rebuilt from scratch on every first slice
  always_ff @(posedge clk) begin
    if (in_fire) begin
      asm_data <= asm_data_next;
      asm_tag  <= asm_tag_next;
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (in_fire && final_slice) begin
      // A load wins over a drain in the same cycle
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Payload loads on the final slice only
  always_ff @(posedge clk) begin
    if (in_fire && final_slice) begin
      out_data      <= asm_data_next;
      out_last      <= in_last;
      out_dont_care <= final_dc;
      out_tag       <= asm_tag_next;
    end
  end

endmodule

`default_nettype wire

// File: hw/flow_serializer.sv
`timescale 1ns/10ps
`default_nettype none

// Cuts a wide flit into narrow slices, least significant slice first
// The path from push to pop is combinational, so the first slice leaves
// in the same cycle the flit is offered
module flow_serializer (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                push_valid,
  output logic                                     push_ready,
  input  wire logic [link_pkg::WIDE_WIDTH-1:0]     push_data,
  input  wire logic                                push_last,
  input  wire logic [link_pkg::SLICE_ID_WIDTH-1:0] push_dont_care,
  input  wire logic [link_pkg::TAG_WIDTH-1:0]      push_tag,
  output logic                                     pop_valid,
  input  wire logic                                pop_ready,
  output logic [link_pkg::NARROW_WIDTH-1:0]        pop_data,
  output logic                                     pop_last,
  output logic [link_pkg::TAG_WIDTH-1:0]           pop_tag
);

  // --------------------------------------------------
  // Slice counter
  // --------------------------------------------------

  // Index of the slice currently offered on the narrow side
  logic [link_pkg::SLICE_ID_WIDTH-1:0] slice_cnt;

  // Counter plus the dropped tail at the index width
  // The sum reaches the top index on the final slice of the flit
  logic [link_pkg::SLICE_ID_WIDTH-1:0] cnt_plus_dc;

  // High on the slice that finishes the current wide flit
  logic                                flit_done;

  // Accepted slice on the narrow side
  logic                                pop_fire;

  assign cnt_plus_dc = slice_cnt + push_dont_care;

  // For a flit that is not last the don't-care count is zero
  // So this reduces to the counter reaching the top slice
  assign flit_done =
    (cnt_plus_dc == (link_pkg::SLICE_ID_WIDTH)'(link_pkg::SLICE_RATIO - 1));

  assign pop_fire = pop_valid && pop_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slice_cnt <= '0;
    end else if (pop_fire) begin
      // The end of a packet restarts the count at once
      // A full flit simply overflows back to zero
      if (pop_last) begin
        slice_cnt <= '0;
      end else begin
        slice_cnt <= slice_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Narrow outputs
  // --------------------------------------------------

  // A slice is on offer whenever a wide flit is
  assign pop_valid = push_valid;

  // Mux the selected slice out of the held flit
  // Slice zero sits in the low bits of the wide word
  assign pop_data = push_data[slice_cnt * link_pkg::NARROW_WIDTH +: link_pkg::NARROW_WIDTH];

  // Only the last flit of a packet marks its final slice
  assign pop_last = push_last && flit_done;

  // The tag is copied onto each slice unchanged
  assign pop_tag = push_tag;

  // --------------------------------------------------
  // Wide side handshake
  // --------------------------------------------------

  // The buffer may drop the flit only once its final slice is taken
  assign push_ready = pop_ready && flit_done;

endmodule

`default_nettype wire

// File: hw/flit_buffer.sv
`timescale 1ns/10ps
`default_nettype none

// Small FIFO in front of the serializer
// The head entry drives the outputs directly from storage, so the fields
// stay put for as many cycles as the serializer needs to scan them
module flit_buffer (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                in_valid,
  output logic                                     in_ready,
  input  wire logic [link_pkg::WIDE_WIDTH-1:0]     in_data,
  input  wire logic                                in_last,
  input  wire logic [link_pkg::SLICE_ID_WIDTH-1:0] in_dont_care,
  input  wire logic [link_pkg::TAG_WIDTH-1:0]      in_tag,
  output logic                                     out_valid,
  input  wire logic                                out_ready,
  output logic [link_pkg::WIDE_WIDTH-1:0]          out_data,
  output logic                                     out_last,
  output logic [link_pkg::SLICE_ID_WIDTH-1:0]      out_dont_care,
  output logic [link_pkg::TAG_WIDTH-1:0]           out_tag
);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------

  // One slot per entry for each field of the flit
  logic [link_pkg::WIDE_WIDTH-1:0]     data_mem [link_pkg::BUFFER_DEPTH];
  logic                                last_mem [link_pkg::BUFFER_DEPTH];
  logic [link_pkg::SLICE_ID_WIDTH-1:0] dc_mem   [link_pkg::BUFFER_DEPTH];
  logic [link_pkg::TAG_WIDTH-1:0]      tag_mem  [link_pkg::BUFFER_DEPTH];

  // Pointers index the entries, the count must also reach the full depth
  logic [$clog2(link_pkg::BUFFER_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(link_pkg::BUFFER_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(link_pkg::BUFFER_DEPTH+1)-1:0] count;

  logic push;
  logic pop;

  // Room is left as long as not every entry is taken
  assign in_ready = (count < link_pkg::BUFFER_DEPTH);

  // Anything held can be offered to the serializer
  assign out_valid = (count != '0);

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers step forward and wrap at the last entry
      if (push) begin
        wr_ptr <= (wr_ptr == ($clog2(link_pkg::BUFFER_DEPTH))'(link_pkg::BUFFER_DEPTH - 1)) ?
                  '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ($clog2(link_pkg::BUFFER_DEPTH))'(link_pkg::BUFFER_DEPTH - 1)) ?
                  '0 : rd_ptr + 1'b1;
      end
      // A push and a pop in the same cycle leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Payload storage is written only on a push
  always_ff @(posedge clk) begin
    if (push) begin
      data_mem[wr_ptr] <= in_data;
      last_mem[wr_ptr] <= in_last;
      dc_mem[wr_ptr]   <= in_dont_care;
      tag_mem[wr_ptr]  <= in_tag;
    end
  end

  // Head entry goes straight out
  assign out_data      = data_mem[rd_ptr];
  assign out_last      = last_mem[rd_ptr];
  assign out_dont_care = dc_mem[rd_ptr];
  assign out_tag       = tag_mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/link_pkg.sv
`default_nettype none

package link_pkg;

  // --------------------------------------------------
  // Link widths
  // --------------------------------------------------

  // Width of one wide flit on the user side of the endpoint
  localparam int WIDE_WIDTH = 32;

  // Width of one slice on the narrow serial link
  localparam int NARROW_WIDTH = 8;

  // Number of narrow slices that make up one wide flit
  // The wide width must be an exact multiple of the narrow width
  localparam int SLICE_RATIO = WIDE_WIDTH / NARROW_WIDTH;

  // Width of a slice index inside a flit
  // The same width carries the count of dropped tail slices
  localparam int SLICE_ID_WIDTH = $clog2(SLICE_RATIO);

  // --------------------------------------------------
  // Sideband and buffering
  // --------------------------------------------------

  // Width of the tag that rides next to every flit and slice
  // It is never sliced, only repeated
  localparam int TAG_WIDTH = 3;

  // Number of wide flits the transmit buffer can hold
  // Two entries let a new flit land while the previous one is being sliced
  localparam int BUFFER_DEPTH = 2;

endpackage

`default_nettype wire
